//--- design/id_consts.svh
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

`define ID_WORD_W           32
`define ID_REG_ADDR_W       5
`define ID_ALUOP_W          8
`define ID_ALUSEL_W         3
`define ID_IMM16_W          16
`define ID_OPCODE_W         6
`define ID_FUNCT_W          6

// primary opcode field
`define ID_OP_SPECIAL       6'b000000
`define ID_OP_ORI           6'b001101
`define ID_OP_ANDI          6'b001100
`define ID_OP_XORI          6'b001110
`define ID_OP_LUI           6'b001111
`define ID_OP_SLTI          6'b001010
`define ID_OP_SLTIU         6'b001011
`define ID_OP_ADDI          6'b001000
`define ID_OP_ADDIU         6'b001001

// function field under SPECIAL
`define ID_FN_OR            6'b100101
`define ID_FN_AND           6'b100100
`define ID_FN_XOR           6'b100110
`define ID_FN_NOR           6'b100111
`define ID_FN_SLLV          6'b000100
`define ID_FN_SRLV          6'b000110
`define ID_FN_SRAV          6'b000111
`define ID_FN_SLL           6'b000000
`define ID_FN_SRL           6'b000010
`define ID_FN_SRA           6'b000011
`define ID_FN_SLT           6'b101010
`define ID_FN_SLTU          6'b101011
`define ID_FN_ADD           6'b100000
`define ID_FN_ADDU          6'b100001
`define ID_FN_SUB           6'b100010
`define ID_FN_SUBU          6'b100011

// alu op codes seen by execute
`define ID_ALU_NOP          8'b00000000
`define ID_ALU_OR           8'b00100101
`define ID_ALU_AND          8'b00100100
`define ID_ALU_XOR          8'b00100110
`define ID_ALU_NOR          8'b00100111
`define ID_ALU_SLL          8'b01111100
`define ID_ALU_SRL          8'b00000010
`define ID_ALU_SRA          8'b00000011
`define ID_ALU_SLT          8'b00101010
`define ID_ALU_SLTU         8'b00101011
`define ID_ALU_ADD          8'b00100000
`define ID_ALU_ADDU         8'b00100001
`define ID_ALU_SUB          8'b00100010
`define ID_ALU_SUBU         8'b00100011
`define ID_ALU_ADDI         8'b01010101
`define ID_ALU_ADDIU        8'b01010110

// result class
`define ID_RES_NOP          3'b000
`define ID_RES_LOGIC        3'b001
`define ID_RES_SHIFT        3'b010
`define ID_RES_ARITHMETIC   3'b100

`endif

//--- design/id_pkg.sv
`default_nettype none

`include "id_consts.svh"

package id_pkg;

    // register format word
    typedef struct packed {
        logic [`ID_OPCODE_W-1:0]    op;
        logic [`ID_REG_ADDR_W-1:0]  rs;
        logic [`ID_REG_ADDR_W-1:0]  rt;
        logic [`ID_REG_ADDR_W-1:0]  rd;
        logic [`ID_REG_ADDR_W-1:0]  shamt;
        logic [`ID_FUNCT_W-1:0]     funct;
    } r_fmt_t;

    // immediate format word
    typedef struct packed {
        logic [`ID_OPCODE_W-1:0]    op;
        logic [`ID_REG_ADDR_W-1:0]  rs;
        logic [`ID_REG_ADDR_W-1:0]  rt;
        logic [`ID_IMM16_W-1:0]     imm16;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_word_u;

    typedef struct packed {
        logic [`ID_ALUOP_W-1:0]     aluop;
        logic [`ID_ALUSEL_W-1:0]    alusel;
        logic [`ID_REG_ADDR_W-1:0]  wd;
        logic                       wreg;
        logic                       reg1_read;
        logic                       reg2_read;
        logic [`ID_REG_ADDR_W-1:0]  reg1_addr;      // rs
        logic [`ID_REG_ADDR_W-1:0]  reg2_addr;      // rt
        logic [`ID_WORD_W-1:0]      imm;
        logic                       undef;
    } dec_ctrl_t;

    // write-back view of a later stage
    typedef struct packed {
        logic                       wreg;
        logic [`ID_REG_ADDR_W-1:0]  wd;
        logic [`ID_WORD_W-1:0]      wdata;
    } fwd_src_t;

    typedef struct packed {
        logic [`ID_ALUOP_W-1:0]     aluop;
        logic [`ID_ALUSEL_W-1:0]    alusel;
        logic [`ID_WORD_W-1:0]      reg1;
        logic [`ID_WORD_W-1:0]      reg2;
        logic [`ID_REG_ADDR_W-1:0]  wd;
        logic                       wreg;
    } id_ex_t;

endpackage

`default_nettype wire

//--- design/inst_decode.sv
`default_nettype none

`include "id_consts.svh"

module inst_decode (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       inst_valid_i,
    input  wire logic [`ID_WORD_W-1:0]      pc_i,
    input  wire logic [`ID_WORD_W-1:0]      inst_i,
    output id_pkg::dec_ctrl_t               dec_o,
    output logic                            held_valid_o
);

    id_pkg::inst_word_u         inst_q;

    logic                       r_ok;
    logic [`ID_ALUOP_W-1:0]     r_aluop;
    logic [`ID_ALUSEL_W-1:0]    r_alusel;
    logic                       s_ok;
    logic [`ID_ALUOP_W-1:0]     s_aluop;
    logic                       i_ok;
    logic [`ID_ALUOP_W-1:0]     i_aluop;
    logic [`ID_ALUSEL_W-1:0]    i_alusel;
    logic [`ID_WORD_W-1:0]      i_imm;

    always_ff @(posedge clk) begin
        if (reset_i || !inst_valid_i) begin
            held_valid_o <= 1'b0;
            inst_q       <= '0;         // empty slot holds a nop
        end else begin
            held_valid_o <= 1'b1;
            inst_q       <= inst_i;
        end
    end

    // SPECIAL with zero shamt
    always_comb begin
        r_ok     = (inst_q.r.op == `ID_OP_SPECIAL) && (inst_q.r.shamt == '0);
        r_alusel = `ID_RES_ARITHMETIC;
        case (inst_q.r.funct)
            `ID_FN_OR: begin
                r_aluop  = `ID_ALU_OR;
                r_alusel = `ID_RES_LOGIC;
            end
            `ID_FN_AND: begin
                r_aluop  = `ID_ALU_AND;
                r_alusel = `ID_RES_LOGIC;
            end
            `ID_FN_XOR: begin
                r_aluop  = `ID_ALU_XOR;
                r_alusel = `ID_RES_LOGIC;
            end
            `ID_FN_NOR: begin
                r_aluop  = `ID_ALU_NOR;
                r_alusel = `ID_RES_LOGIC;
            end
            `ID_FN_SLLV: begin
                r_aluop  = `ID_ALU_SLL;
                r_alusel = `ID_RES_SHIFT;
            end
            `ID_FN_SRLV: begin
                r_aluop  = `ID_ALU_SRL;
                r_alusel = `ID_RES_SHIFT;
            end
            `ID_FN_SRAV: begin
                r_aluop  = `ID_ALU_SRA;
                r_alusel = `ID_RES_SHIFT;
            end
            `ID_FN_SLT:  r_aluop = `ID_ALU_SLT;
            `ID_FN_SLTU: r_aluop = `ID_ALU_SLTU;
            `ID_FN_ADD:  r_aluop = `ID_ALU_ADD;
            `ID_FN_ADDU: r_aluop = `ID_ALU_ADDU;
            `ID_FN_SUB:  r_aluop = `ID_ALU_SUB;
            `ID_FN_SUBU: r_aluop = `ID_ALU_SUBU;
            default: begin
                r_aluop  = `ID_ALU_NOP;
                r_alusel = `ID_RES_NOP;
                r_ok     = 1'b0;
            end
        endcase
    end

    // constant shifts need op and rs all zero
    always_comb begin
        s_ok = (inst_q.r.op == '0) && (inst_q.r.rs == '0);
        case (inst_q.r.funct)
            `ID_FN_SLL: s_aluop = `ID_ALU_SLL;
            `ID_FN_SRL: s_aluop = `ID_ALU_SRL;
            `ID_FN_SRA: s_aluop = `ID_ALU_SRA;
            default: begin
                s_aluop = `ID_ALU_NOP;
                s_ok    = 1'b0;
            end
        endcase
    end

    always_comb begin
        i_ok     = 1'b1;
        i_alusel = `ID_RES_ARITHMETIC;
        i_imm    = {{(`ID_WORD_W-`ID_IMM16_W){inst_q.i.imm16[`ID_IMM16_W-1]}}, inst_q.i.imm16};
        case (inst_q.i.op)
            `ID_OP_ORI,
            `ID_OP_ANDI,
            `ID_OP_XORI: begin
                i_alusel = `ID_RES_LOGIC;
                i_imm    = {{(`ID_WORD_W-`ID_IMM16_W){1'b0}}, inst_q.i.imm16};
                i_aluop  = (inst_q.i.op == `ID_OP_ORI)  ? `ID_ALU_OR  :
                           (inst_q.i.op == `ID_OP_ANDI) ? `ID_ALU_AND : `ID_ALU_XOR;
            end
            `ID_OP_LUI: begin
                i_aluop  = `ID_ALU_OR;                 // rs or'd with upper half
                i_alusel = `ID_RES_LOGIC;
                i_imm    = {inst_q.i.imm16, {(`ID_WORD_W-`ID_IMM16_W){1'b0}}};
            end
            `ID_OP_SLTI:  i_aluop = `ID_ALU_SLT;
            `ID_OP_SLTIU: i_aluop = `ID_ALU_SLTU;
            `ID_OP_ADDI:  i_aluop = `ID_ALU_ADDI;
            `ID_OP_ADDIU: i_aluop = `ID_ALU_ADDIU;
            default: begin
                i_aluop  = `ID_ALU_NOP;
                i_alusel = `ID_RES_NOP;
                i_ok     = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec_o           = '0;
        dec_o.aluop     = `ID_ALU_NOP;
        dec_o.alusel    = `ID_RES_NOP;
        dec_o.wd        = inst_q.r.rd;
        dec_o.reg1_addr = inst_q.r.rs;
        dec_o.reg2_addr = inst_q.r.rt;
        dec_o.undef     = 1'b1;
        if (s_ok) begin
            dec_o.aluop     = s_aluop;
            dec_o.alusel    = `ID_RES_SHIFT;
            dec_o.wreg      = 1'b1;
            dec_o.reg2_read = 1'b1;
            dec_o.imm       = {{(`ID_WORD_W-`ID_REG_ADDR_W){1'b0}}, inst_q.r.shamt};
            dec_o.undef     = 1'b0;
        end else if (r_ok) begin
            dec_o.aluop     = r_aluop;
            dec_o.alusel    = r_alusel;
            dec_o.wreg      = 1'b1;
            dec_o.reg1_read = 1'b1;
            dec_o.reg2_read = 1'b1;
            dec_o.undef     = 1'b0;
        end else if (i_ok) begin
            dec_o.aluop     = i_aluop;
            dec_o.alusel    = i_alusel;
            dec_o.wd        = inst_q.i.rt;             // rt is the target here
            dec_o.wreg      = 1'b1;
            dec_o.reg1_read = 1'b1;
            dec_o.imm       = i_imm;
            dec_o.undef     = 1'b0;
        end
        if (!held_valid_o) begin
            dec_o.reg1_read = 1'b0;                    // no reads on an empty slot
            dec_o.reg2_read = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/operand_fetch.sv
`default_nettype none

`include "id_consts.svh"

module operand_fetch (
    input  wire id_pkg::dec_ctrl_t          dec_i,
    input  wire id_pkg::fwd_src_t           ex_fwd_i,
    input  wire id_pkg::fwd_src_t           mem_fwd_i,
    input  wire logic [`ID_WORD_W-1:0]      rf_rdata1_i,
    input  wire logic [`ID_WORD_W-1:0]      rf_rdata2_i,
    output logic                            rf_re1_o,
    output logic                            rf_re2_o,
    output logic [`ID_REG_ADDR_W-1:0]       rf_raddr1_o,
    output logic [`ID_REG_ADDR_W-1:0]       rf_raddr2_o,
    output id_pkg::id_ex_t                  id_ex_o
);

    // ex wins over mem, both win over the register file
    function automatic logic [`ID_WORD_W-1:0] pick_operand(
        input logic                         re,
        input logic [`ID_REG_ADDR_W-1:0]    addr,
        input id_pkg::fwd_src_t             ex_fwd,
        input id_pkg::fwd_src_t             mem_fwd,
        input logic [`ID_WORD_W-1:0]        rf_data,
        input logic [`ID_WORD_W-1:0]        imm
    );
        if (!re) begin
            return imm;
        end else if (ex_fwd.wreg && (ex_fwd.wd == addr)) begin
            return ex_fwd.wdata;
        end else if (mem_fwd.wreg && (mem_fwd.wd == addr)) begin
            return mem_fwd.wdata;
        end
        return rf_data;
    endfunction

    assign rf_re1_o    = dec_i.reg1_read;
    assign rf_re2_o    = dec_i.reg2_read;
    assign rf_raddr1_o = dec_i.reg1_addr;
    assign rf_raddr2_o = dec_i.reg2_addr;

    always_comb begin
        id_ex_o.aluop  = dec_i.aluop;
        id_ex_o.alusel = dec_i.alusel;
        id_ex_o.reg1   = pick_operand(dec_i.reg1_read, dec_i.reg1_addr, ex_fwd_i,
                                      mem_fwd_i, rf_rdata1_i, dec_i.imm);
        id_ex_o.reg2   = pick_operand(dec_i.reg2_read, dec_i.reg2_addr, ex_fwd_i,
                                      mem_fwd_i, rf_rdata2_i, dec_i.imm);
        id_ex_o.wd     = dec_i.wd;
        id_ex_o.wreg   = dec_i.wreg;
    end

endmodule

`default_nettype wire

//--- design/id_ex_reg.sv
`default_nettype none

`include "id_consts.svh"

module id_ex_reg (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       valid_i,
    input  wire logic                       undef_i,
    input  wire id_pkg::id_ex_t             id_ex_i,
    output id_pkg::id_ex_t                  id_ex_o,
    output logic                            ex_valid_o,
    output logic                            undef_inst_o
);

    logic [`ID_ALUOP_W-1:0]     aluop_q;
    logic [`ID_ALUSEL_W-1:0]    alusel_q;
    logic                       wreg_q;
    logic [`ID_REG_ADDR_W-1:0]  wd_q;
    logic [`ID_WORD_W-1:0]      reg1_q;
    logic [`ID_WORD_W-1:0]      reg2_q;

    always_ff @(posedge clk) begin
        if (reset_i || !valid_i) begin
            aluop_q      <= `ID_ALU_NOP;   // bubble
            alusel_q     <= `ID_RES_NOP;
            wreg_q       <= 1'b0;
            ex_valid_o   <= 1'b0;
            undef_inst_o <= 1'b0;
        end else begin
            aluop_q      <= id_ex_i.aluop;
            alusel_q     <= id_ex_i.alusel;
            wreg_q       <= id_ex_i.wreg;
            ex_valid_o   <= 1'b1;
            undef_inst_o <= undef_i;        // one cycle, tracks ex_valid_o
        end
    end

    always_ff @(posedge clk) begin
        wd_q   <= id_ex_i.wd;
        reg1_q <= id_ex_i.reg1;
        reg2_q <= id_ex_i.reg2;
    end

    always_comb begin
        id_ex_o.aluop  = aluop_q;
        id_ex_o.alusel = alusel_q;
        id_ex_o.reg1   = reg1_q;
        id_ex_o.reg2   = reg2_q;
        id_ex_o.wd     = wd_q;
        id_ex_o.wreg   = wreg_q;
    end

endmodule

`default_nettype wire

//--- design/id_top.sv
`default_nettype none

`include "id_consts.svh"

module id_top (
    input  wire logic                       clk,
    input  wire logic                       reset_i,

    input  wire logic                       inst_valid_i,
    input  wire logic [`ID_WORD_W-1:0]      pc_i,
    input  wire logic [`ID_WORD_W-1:0]      inst_i,

    input  wire id_pkg::fwd_src_t           ex_fwd_i,
    input  wire id_pkg::fwd_src_t           mem_fwd_i,

    input  wire logic [`ID_WORD_W-1:0]      rf_rdata1_i,
    input  wire logic [`ID_WORD_W-1:0]      rf_rdata2_i,
    output logic                            rf_re1_o,
    output logic                            rf_re2_o,
    output logic [`ID_REG_ADDR_W-1:0]       rf_raddr1_o,
    output logic [`ID_REG_ADDR_W-1:0]       rf_raddr2_o,

    output id_pkg::id_ex_t                  id_ex_o,
    output logic                            ex_valid_o,
    output logic                            undef_inst_o
);

    id_pkg::dec_ctrl_t          dec;
    logic                       held_valid;
    id_pkg::id_ex_t             id_ex_d;       // operands not yet registered

    inst_decode u_inst_decode (
        .clk            (clk),
        .reset_i        (reset_i),
        .inst_valid_i   (inst_valid_i),
        .pc_i           (pc_i),
        .inst_i         (inst_i),
        .dec_o          (dec),
        .held_valid_o   (held_valid)
    );

    operand_fetch u_operand_fetch (
        .dec_i          (dec),
        .ex_fwd_i       (ex_fwd_i),
        .mem_fwd_i      (mem_fwd_i),
        .rf_rdata1_i    (rf_rdata1_i),
        .rf_rdata2_i    (rf_rdata2_i),
        .rf_re1_o       (rf_re1_o),
        .rf_re2_o       (rf_re2_o),
        .rf_raddr1_o    (rf_raddr1_o),
        .rf_raddr2_o    (rf_raddr2_o),
        .id_ex_o        (id_ex_d)
    );

    id_ex_reg u_id_ex_reg (
        .clk            (clk),
        .reset_i        (reset_i),
        .valid_i        (held_valid),
        .undef_i        (dec.undef),
        .id_ex_i        (id_ex_d),
        .id_ex_o        (id_ex_o),
        .ex_valid_o     (ex_valid_o),
        .undef_inst_o   (undef_inst_o)
    );

endmodule

`default_nettype wire

//--- dv/tb_id_top.sv
`default_nettype none

`include "id_consts.svh"

module tb_id_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 20;
    localparam int CODE_W = `ID_ALUOP_W + `ID_ALUSEL_W;

    logic                       clk = 1'b0;
    logic                       reset_i;
    logic                       inst_valid_i;
    logic [`ID_WORD_W-1:0]      pc_i;
    logic [`ID_WORD_W-1:0]      inst_i;
    id_pkg::fwd_src_t           ex_fwd_i;
    id_pkg::fwd_src_t           mem_fwd_i;
    logic [`ID_WORD_W-1:0]      rf_rdata1_i;
    logic [`ID_WORD_W-1:0]      rf_rdata2_i;
    logic                       rf_re1_o;
    logic                       rf_re2_o;
    logic [`ID_REG_ADDR_W-1:0]  rf_raddr1_o;
    logic [`ID_REG_ADDR_W-1:0]  rf_raddr2_o;
    id_pkg::id_ex_t             id_ex_o;
    logic                       ex_valid_o;
    logic                       undef_inst_o;

    logic [`ID_WORD_W-1:0]      rf_mem [32];
    logic [`ID_WORD_W-1:0]      pc_next;
    int                         seed;

    always #2 clk = ~clk;

    id_top u_dut (
        .clk            (clk),
        .reset_i        (reset_i),
        .inst_valid_i   (inst_valid_i),
        .pc_i           (pc_i),
        .inst_i         (inst_i),
        .ex_fwd_i       (ex_fwd_i),
        .mem_fwd_i      (mem_fwd_i),
        .rf_rdata1_i    (rf_rdata1_i),
        .rf_rdata2_i    (rf_rdata2_i),
        .rf_re1_o       (rf_re1_o),
        .rf_re2_o       (rf_re2_o),
        .rf_raddr1_o    (rf_raddr1_o),
        .rf_raddr2_o    (rf_raddr2_o),
        .id_ex_o        (id_ex_o),
        .ex_valid_o     (ex_valid_o),
        .undef_inst_o   (undef_inst_o)
    );

    assign rf_rdata1_i = rf_mem[rf_raddr1_o];  // register file model, async read
    assign rf_rdata2_i = rf_mem[rf_raddr2_o];

    function automatic logic [`ID_WORD_W-1:0] rand_word();
        return $random(seed);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input logic [95:0] got, input logic [95:0] exp,
                                 input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at time %0t: %s got %0h expected %0h",
                                $time, what, got, exp));
        end
    endtask

    function automatic logic [CODE_W-1:0] funct_code(input logic [5:0] fn);
        case (fn)
            `ID_FN_OR:   return {`ID_ALU_OR, `ID_RES_LOGIC};
            `ID_FN_AND:  return {`ID_ALU_AND, `ID_RES_LOGIC};
            `ID_FN_XOR:  return {`ID_ALU_XOR, `ID_RES_LOGIC};
            `ID_FN_NOR:  return {`ID_ALU_NOR, `ID_RES_LOGIC};
            `ID_FN_SLL,
            `ID_FN_SLLV: return {`ID_ALU_SLL, `ID_RES_SHIFT};
            `ID_FN_SRL,
            `ID_FN_SRLV: return {`ID_ALU_SRL, `ID_RES_SHIFT};
            `ID_FN_SRA,
            `ID_FN_SRAV: return {`ID_ALU_SRA, `ID_RES_SHIFT};
            `ID_FN_SLT:  return {`ID_ALU_SLT, `ID_RES_ARITHMETIC};
            `ID_FN_SLTU: return {`ID_ALU_SLTU, `ID_RES_ARITHMETIC};
            `ID_FN_ADD:  return {`ID_ALU_ADD, `ID_RES_ARITHMETIC};
            `ID_FN_ADDU: return {`ID_ALU_ADDU, `ID_RES_ARITHMETIC};
            `ID_FN_SUB:  return {`ID_ALU_SUB, `ID_RES_ARITHMETIC};
            `ID_FN_SUBU: return {`ID_ALU_SUBU, `ID_RES_ARITHMETIC};
            default:     return {`ID_ALU_NOP, `ID_RES_NOP};
        endcase
    endfunction

    function automatic logic [CODE_W-1:0] opcode_code(input logic [5:0] op);
        case (op)
            `ID_OP_ORI,
            `ID_OP_LUI:   return {`ID_ALU_OR, `ID_RES_LOGIC};
            `ID_OP_ANDI:  return {`ID_ALU_AND, `ID_RES_LOGIC};
            `ID_OP_XORI:  return {`ID_ALU_XOR, `ID_RES_LOGIC};
            `ID_OP_SLTI:  return {`ID_ALU_SLT, `ID_RES_ARITHMETIC};
            `ID_OP_SLTIU: return {`ID_ALU_SLTU, `ID_RES_ARITHMETIC};
            `ID_OP_ADDI:  return {`ID_ALU_ADDI, `ID_RES_ARITHMETIC};
            `ID_OP_ADDIU: return {`ID_ALU_ADDIU, `ID_RES_ARITHMETIC};
            default:      return {`ID_ALU_NOP, `ID_RES_NOP};
        endcase
    endfunction

    // reference decoder built from the instruction formats
    function automatic id_pkg::dec_ctrl_t ref_decode(input logic [`ID_WORD_W-1:0] w);
        id_pkg::dec_ctrl_t d;
        logic [CODE_W-1:0] code;
        d = '0;
        d.reg1_addr = w[25:21];
        d.reg2_addr = w[20:16];
        d.wd = w[15:11];
        if (w[31:21] == 11'd0 && w[5:0] inside {`ID_FN_SLL, `ID_FN_SRL, `ID_FN_SRA}) begin
            code = funct_code(w[5:0]);
            d.reg2_read = 1'b1;
            d.imm = {27'd0, w[10:6]};       // shamt
        end else if (w[31:26] == `ID_OP_SPECIAL && w[10:6] == 5'd0 &&
                     !(w[5:0] inside {`ID_FN_SLL, `ID_FN_SRL, `ID_FN_SRA})) begin
            code = funct_code(w[5:0]);
            d.reg1_read = 1'b1;
            d.reg2_read = 1'b1;
        end else begin
            code = opcode_code(w[31:26]);
            d.reg1_read = 1'b1;
            d.wd = w[20:16];
            if (w[31:26] == `ID_OP_LUI)
                d.imm = {w[15:0], 16'd0};
            else if (code[`ID_ALUSEL_W-1:0] == `ID_RES_LOGIC)
                d.imm = {16'd0, w[15:0]};
            else
                d.imm = {{16{w[15]}}, w[15:0]};
        end
        {d.aluop, d.alusel} = code;
        d.undef = (d.alusel == `ID_RES_NOP);
        d.wreg = !d.undef;
        if (d.undef) begin
            d.reg1_read = 1'b0;
            d.reg2_read = 1'b0;
        end
        return d;
    endfunction

    function automatic logic [`ID_WORD_W-1:0] ref_operand(input logic re,
            input logic [`ID_REG_ADDR_W-1:0] addr, input logic [`ID_WORD_W-1:0] imm);
        logic [`ID_WORD_W-1:0] v;
        v = imm;
        if (re) begin
            v = rf_mem[addr];
            if (mem_fwd_i.wreg && mem_fwd_i.wd == addr)
                v = mem_fwd_i.wdata;
            if (ex_fwd_i.wreg && ex_fwd_i.wd == addr)
                v = ex_fwd_i.wdata;         // newer result overrides
        end
        return v;
    endfunction

    function automatic logic [`ID_WORD_W-1:0] r_word(input logic [5:0] fn,
            input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd);
        return {`ID_OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_inst(input logic [`ID_WORD_W-1:0] word);
        inst_i = word;
        pc_i = pc_next;
        inst_valid_i = 1'b1;
        pc_next = pc_next + 32'd4;
    endtask

    task automatic wait_result(output int cycles);
        cycles = 0;
        do begin
            next_cycle();
            cycles++;
        end while (!ex_valid_o && cycles < TIMEOUT_CYCLES);
        if (!ex_valid_o)
            abort_run("timeout: ex_valid_o never rose after an accepted instruction");
    endtask

    task automatic check_result(input id_pkg::dec_ctrl_t d, input string name);
        compare_value(96'(ex_valid_o), 96'(1'b1), {name, ": ex_valid_o"});
        compare_value(96'(undef_inst_o), 96'(d.undef), {name, ": undef_inst_o"});
        compare_value(96'(id_ex_o.aluop), 96'(d.aluop), {name, ": aluop"});
        compare_value(96'(id_ex_o.alusel), 96'(d.alusel), {name, ": alusel"});
        compare_value(96'(id_ex_o.wreg), 96'(d.wreg), {name, ": wreg"});
        if (!d.undef) begin
            compare_value(96'(id_ex_o.wd), 96'(d.wd), {name, ": wd"});
            compare_value(96'(id_ex_o.reg1), 96'(ref_operand(d.reg1_read, d.reg1_addr,
                          d.imm)), {name, ": reg1"});
            compare_value(96'(id_ex_o.reg2), 96'(ref_operand(d.reg2_read, d.reg2_addr,
                          d.imm)), {name, ": reg2"});
        end
    endtask

    task automatic run_single(input logic [`ID_WORD_W-1:0] word, input string name);
        id_pkg::dec_ctrl_t d;
        int cycles;
        d = ref_decode(word);
        drive_inst(word);
        next_cycle();
        inst_valid_i = 1'b0;
        compare_value(96'(rf_re1_o), 96'(d.reg1_read), {name, ": rf_re1_o"});
        compare_value(96'(rf_re2_o), 96'(d.reg2_read), {name, ": rf_re2_o"});
        if (d.reg1_read)
            compare_value(96'(rf_raddr1_o), 96'(d.reg1_addr), {name, ": rf_raddr1_o"});
        if (d.reg2_read)
            compare_value(96'(rf_raddr2_o), 96'(d.reg2_addr), {name, ": rf_raddr2_o"});
        wait_result(cycles);
        compare_value(96'(cycles), 96'(1), {name, ": latency"});
        check_result(d, name);
    endtask

    task automatic check_reset();
        for (int i = 0; i <= 8; i++) begin
            next_cycle();
            if (i == 7)
                reset_i = 1'b0;
            if (i > 0) begin
                compare_value(96'(ex_valid_o), 96'(1'b0), "reset: ex_valid_o");
                compare_value(96'(undef_inst_o), 96'(1'b0), "reset: undef_inst_o");
                compare_value(96'(id_ex_o.wreg), 96'(1'b0), "reset: wreg");
                compare_value(96'(rf_re1_o), 96'(1'b0), "reset: rf_re1_o");
                compare_value(96'(rf_re2_o), 96'(1'b0), "reset: rf_re2_o");
            end
        end
    endtask

    task automatic test_rtype();
        logic [5:0] fns [13] = '{`ID_FN_OR, `ID_FN_AND, `ID_FN_XOR, `ID_FN_NOR,
            `ID_FN_SLLV, `ID_FN_SRLV, `ID_FN_SRAV, `ID_FN_SLT, `ID_FN_SLTU,
            `ID_FN_ADD, `ID_FN_ADDU, `ID_FN_SUB, `ID_FN_SUBU};
        logic [`ID_WORD_W-1:0] r;
        logic [`ID_WORD_W-1:0] a;
        logic [`ID_WORD_W-1:0] b;
        for (int i = 0; i < 13; i++) begin
            r = rand_word();
            run_single(r_word(fns[i], r[4:0], r[9:5], r[14:10]), $sformatf("rtype %0d", i));
        end
        r = rand_word();
        a = r_word(`ID_FN_ADD, r[4:0], r[9:5], r[14:10]);
        b = r_word(`ID_FN_NOR, r[19:15], r[24:20], r[29:25]);
        drive_inst(a);
        next_cycle();
        drive_inst(b);                      // back to back
        next_cycle();
        inst_valid_i = 1'b0;
        check_result(ref_decode(a), "pair first");
        next_cycle();
        check_result(ref_decode(b), "pair second");
        next_cycle();
        compare_value(96'(ex_valid_o), 96'(1'b0), "pair: bubble after");
    endtask

    task automatic test_imm();
        logic [5:0] ops [8] = '{`ID_OP_ORI, `ID_OP_ANDI, `ID_OP_XORI, `ID_OP_LUI,
            `ID_OP_SLTI, `ID_OP_SLTIU, `ID_OP_ADDI, `ID_OP_ADDIU};
        logic [`ID_WORD_W-1:0] r;
        for (int i = 0; i < 16; i++) begin
            r = rand_word();
            r[15] = i[3];                   // both signs of imm16
            run_single({ops[i % 8], r[25:16], r[15:0]}, $sformatf("imm %0d", i));
        end
    endtask

    task automatic test_const_shift();
        logic [5:0] fns [3] = '{`ID_FN_SLL, `ID_FN_SRL, `ID_FN_SRA};
        logic [`ID_WORD_W-1:0] r;
        for (int i = 0; i < 6; i++) begin
            r = rand_word();
            run_single({11'd0, r[14:0], fns[i % 3]}, $sformatf("shift %0d", i));
        end
    endtask

    task automatic test_forward();
        ex_fwd_i = {1'b1, 5'd5, 32'hE0E0_0001};
        mem_fwd_i = {1'b1, 5'd5, 32'hA0A0_0002};
        run_single(r_word(`ID_FN_ADD, 5'd5, 5'd9, 5'd7), "fwd ex over mem");
        compare_value(96'(id_ex_o.reg1), 96'(32'hE0E0_0001), "fwd ex over mem: reg1");
        ex_fwd_i = {1'b0, 5'd9, 32'hE0E0_0003};
        mem_fwd_i = {1'b1, 5'd9, 32'hA0A0_0004};
        run_single(r_word(`ID_FN_SUB, 5'd5, 5'd9, 5'd7), "fwd mem only");
        compare_value(96'(id_ex_o.reg2), 96'(32'hA0A0_0004), "fwd mem only: reg2");
        ex_fwd_i = {1'b1, 5'd9, 32'hE0E0_0005};
        run_single({`ID_OP_ORI, 5'd5, 5'd9, 16'h8123}, "fwd read disabled");
        compare_value(96'(id_ex_o.reg2), 96'(32'h0000_8123), "fwd read disabled: reg2");
        ex_fwd_i = {1'b1, 5'd0, 32'hE0E0_0006};
        run_single({11'd0, 5'd9, 5'd7, 5'd4, `ID_FN_SLL}, "fwd shift amount");
        ex_fwd_i = '0;
        mem_fwd_i = '0;
    endtask

    task automatic test_undef();
        logic [`ID_WORD_W-1:0] words [4];
        words[0] = r_word(6'b011000, 5'd3, 5'd4, 5'd0);           // mult
        words[1] = {6'b011100, 5'd3, 5'd6, 5'd6, 5'd0, 6'b100000}; // clz
        words[2] = {26'd0, 6'b001111};                            // sync
        words[3] = {`ID_OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd3, `ID_FN_ADD};
        for (int i = 0; i < 4; i++) begin
            run_single(words[i], $sformatf("undef %0d", i));
            next_cycle();
            compare_value(96'(undef_inst_o), 96'(1'b0), "undef: pulse too long");
            compare_value(96'(ex_valid_o), 96'(1'b0), "undef: ex_valid_o after");
        end
    endtask

    initial begin
        reset_i = 1'b1;
        inst_valid_i = 1'b0;
        pc_i = '0;
        inst_i = '0;
        ex_fwd_i = '0;
        mem_fwd_i = '0;
        pc_next = 32'h0040_0000;
        seed = 35023;
        for (int i = 0; i < 32; i++)
            rf_mem[i] = rand_word();
        check_reset();
        test_rtype();
        test_imm();
        test_const_shift();
        test_forward();
        test_undef();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+design
design/id_pkg.sv
design/inst_decode.sv
design/operand_fetch.sv
design/id_ex_reg.sv
design/id_top.sv
dv/tb_id_top.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f sim.f --top-module tb_id_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/Vtb_id_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
